/* Bender.yml */
package:
  name: analog_core

sources:
  - analog_pkg.sv
  - sys_bus_decoder.sv
  - hk_regs.sv
  - ctrl_regs.sv
  - adc_front.sv
  - prop_ctrl.sv
  - dac_back.sv
  - analog_core.sv
  - target: test
    files:
      - tb_analog_core.sv

/* adc_front.sv */
`timescale 1ns/1ps

module adc_front import analog_pkg::*; (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  logic [ADC_W-1:0] adc_dat_a_i,     // neg-slope offset binary
  input  logic [ADC_W-1:0] adc_dat_b_i,
  input  logic             digital_loop_i,  // take dac samples instead
  input  sample_t          loop_a_i,
  input  sample_t          loop_b_i,
  output sample_t          adc_a_o,
  output sample_t          adc_b_o
);

  sample_t pin_a;
  sample_t pin_b;

  // pin words to two's complement
  assign pin_a = nslope_to_signed(adc_dat_a_i);
  assign pin_b = nslope_to_signed(adc_dat_b_i);

  // ------------------------------------------------------------------------
  // input register, one cycle from either source
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else if (digital_loop_i) begin
      adc_a_o <= loop_a_i;  // pins ignored in loopback
      adc_b_o <= loop_b_i;
    end else begin
      adc_a_o <= pin_a;
      adc_b_o <= pin_b;
    end
  end

endmodule

/* analog_core.sv */
`timescale 1ns/1ps

module analog_core import analog_pkg::*; #(
  parameter int KP_SHIFT = 8,
  parameter int LED_W    = 8
) (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  logic [ADC_W-1:0] adc_dat_a_i,
  input  logic [ADC_W-1:0] adc_dat_b_i,
  output logic [ADC_W-1:0] dac_dat_a_o,
  output logic [ADC_W-1:0] dac_dat_b_o,
  output logic [LED_W-1:0] led_o,
  input  logic [BUS_W-1:0] sys_addr_i,
  input  logic [BUS_W-1:0] sys_wdata_i,
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  output logic [BUS_W-1:0] sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o
);

  // ------------------------------------------------------------------------
  // bus side
  logic             hk_wen, hk_ren, hk_ack, hk_err;
  logic             ctrl_wen, ctrl_ren, ctrl_ack, ctrl_err;
  logic [BUS_W-1:0] hk_rdata, ctrl_rdata;

  // data path
  logic                   digital_loop;
  sample_t                dc_a, dc_b;
  logic signed [KP_W-1:0] kp_a, kp_b;
  sample_t                adc_a, adc_b;
  sample_t                pid_a, pid_b;
  sample_t                loop_a, loop_b;  // dac value back to adc side

  sys_bus_decoder i_dec (
    .adc_clk      (adc_clk),      .reset_i      (reset_i),
    .sys_addr_i   (sys_addr_i),   .sys_wen_i    (sys_wen_i),     .sys_ren_i (sys_ren_i),
    .hk_rdata_i   (hk_rdata),     .hk_ack_i     (hk_ack),        .hk_err_i  (hk_err),
    .ctrl_rdata_i (ctrl_rdata),   .ctrl_ack_i   (ctrl_ack),      .ctrl_err_i (ctrl_err),
    .hk_wen_o     (hk_wen),       .hk_ren_o     (hk_ren),
    .ctrl_wen_o   (ctrl_wen),     .ctrl_ren_o   (ctrl_ren),
    .sys_rdata_o  (sys_rdata_o),  .sys_ack_o    (sys_ack_o),     .sys_err_o (sys_err_o)
  );

  // region 0
  hk_regs #(.LED_W(LED_W)) i_hk (
    .adc_clk     (adc_clk),     .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (hk_wen),      .sys_ren_i   (hk_ren),
    .sys_rdata_o (hk_rdata),    .sys_ack_o   (hk_ack),      .sys_err_o (hk_err),
    .digital_loop_o (digital_loop),
    .led_o       (led_o)
  );

  // region 1
  ctrl_regs i_ctrl (
    .adc_clk     (adc_clk),     .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (ctrl_wen),    .sys_ren_i   (ctrl_ren),
    .sys_rdata_o (ctrl_rdata),  .sys_ack_o   (ctrl_ack),    .sys_err_o (ctrl_err),
    .dc_a_o      (dc_a),        .dc_b_o      (dc_b),
    .kp_a_o      (kp_a),        .kp_b_o      (kp_b)
  );

  // ------------------------------------------------------------------------
  // adc -> controller -> dac, four cycles pin to pin
  adc_front i_adc (
    .adc_clk     (adc_clk),      .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),  .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i    (loop_a),       .loop_b_i    (loop_b),
    .adc_a_o     (adc_a),        .adc_b_o     (adc_b)
  );

  prop_ctrl #(.KP_SHIFT(KP_SHIFT)) i_pid (
    .adc_clk (adc_clk),  .reset_i (reset_i),
    .adc_a_i (adc_a),    .adc_b_i (adc_b),
    .kp_a_i  (kp_a),     .kp_b_i  (kp_b),
    .pid_a_o (pid_a),    .pid_b_o (pid_b)
  );

  dac_back i_dac (
    .adc_clk     (adc_clk),      .reset_i     (reset_i),
    .pid_a_i     (pid_a),        .pid_b_i     (pid_b),
    .dc_a_i      (dc_a),         .dc_b_i      (dc_b),
    .dac_dat_a_o (dac_dat_a_o),  .dac_dat_b_o (dac_dat_b_o),
    .loop_a_o    (loop_a),       .loop_b_o    (loop_b)
  );

endmodule

/* analog_pkg.sv */
package analog_pkg;

  // ------------------------------------------------------------------------
  // widths
  localparam int ADC_W    = 14;  // converter word, adc and dac alike
  localparam int SUM_W    = 15;  // dc + pid before clamp
  localparam int KP_W     = 12;  // signed gain
  localparam int BUS_W    = 32;  // sys bus addr and data
  localparam int N_REGION = 8;   // 1 MiB each
  localparam int REGION_W = 3;
  localparam int OFS_W    = 20;

  typedef logic signed [ADC_W-1:0] sample_t;

  localparam sample_t SMP_MAX = {1'b0, {(ADC_W-1){1'b1}}};
  localparam sample_t SMP_MIN = {1'b1, {(ADC_W-1){1'b0}}};

  // ------------------------------------------------------------------------
  // region map and register offsets
  localparam logic [REGION_W-1:0] REGION_HK   = 3'd0;
  localparam logic [REGION_W-1:0] REGION_CTRL = 3'd1;

  localparam logic [BUS_W-1:0] HK_ID = 32'h0a0c_0001;

  localparam logic [OFS_W-1:0] HK_OFS_ID     = 20'h00;
  localparam logic [OFS_W-1:0] HK_OFS_LOOP   = 20'h04;
  localparam logic [OFS_W-1:0] HK_OFS_LED    = 20'h08;
  localparam logic [OFS_W-1:0] CTRL_OFS_DC_A = 20'h00;
  localparam logic [OFS_W-1:0] CTRL_OFS_DC_B = 20'h04;
  localparam logic [OFS_W-1:0] CTRL_OFS_KP_A = 20'h08;
  localparam logic [OFS_W-1:0] CTRL_OFS_KP_B = 20'h0C;

  // bus address, raw word or region/offset split
  typedef union packed {
    logic [BUS_W-1:0] raw;
    struct packed {
      logic [BUS_W-REGION_W-OFS_W-1:0] unused;  // ignored by decoder
      logic [REGION_W-1:0]             region;  // bits 22..20
      logic [OFS_W-1:0]                offset;
    } f;
  } sys_addr_u;

  // neg-slope offset binary -> two's complement, msb kept
  function automatic sample_t nslope_to_signed(input logic [ADC_W-1:0] code);
    return {code[ADC_W-1], ~code[ADC_W-2:0]};
  endfunction

  // same rule the other way round
  function automatic logic [ADC_W-1:0] signed_to_nslope(input sample_t smp);
    return {smp[ADC_W-1], ~smp[ADC_W-2:0]};
  endfunction

  // clamp to sample range
  function automatic sample_t sat_to_sample(input logic signed [BUS_W-1:0] v);
    if (v > SMP_MAX) return SMP_MAX;
    if (v < SMP_MIN) return SMP_MIN;
    return v[ADC_W-1:0];
  endfunction

endpackage

/* ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs import analog_pkg::*; (
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  logic [BUS_W-1:0]       sys_addr_i,
  input  logic [BUS_W-1:0]       sys_wdata_i,
  input  logic                   sys_wen_i,
  input  logic                   sys_ren_i,
  output logic [BUS_W-1:0]       sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o,
  output sample_t                dc_a_o,    // dc level, dac stage
  output sample_t                dc_b_o,
  output logic signed [KP_W-1:0] kp_a_o,    // gains, controller
  output logic signed [KP_W-1:0] kp_b_o
);

  sys_addr_u        addr_u;
  logic             hit;      // offset maps to a register
  logic [BUS_W-1:0] rd_val;

  assign addr_u.raw = sys_addr_i;

  // ------------------------------------------------------------------------
  // offset decode, readback sign extended to bus width
  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (addr_u.f.offset)
      CTRL_OFS_DC_A: rd_val = BUS_W'(dc_a_o);
      CTRL_OFS_DC_B: rd_val = BUS_W'(dc_b_o);
      CTRL_OFS_KP_A: rd_val = BUS_W'(kp_a_o);
      CTRL_OFS_KP_B: rd_val = BUS_W'(kp_b_o);
      default:       hit    = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------------
  // registers, low bits of wdata taken
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
      dc_a_o    <= '0;
      dc_b_o    <= '0;
      kp_a_o    <= '0;
      kp_b_o    <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~hit;  // all four are r/w
      if (sys_wen_i) begin
        case (addr_u.f.offset)
          CTRL_OFS_DC_A: dc_a_o <= sys_wdata_i[ADC_W-1:0];
          CTRL_OFS_DC_B: dc_b_o <= sys_wdata_i[ADC_W-1:0];
          CTRL_OFS_KP_A: kp_a_o <= sys_wdata_i[KP_W-1:0];
          CTRL_OFS_KP_B: kp_b_o <= sys_wdata_i[KP_W-1:0];
          default: ;                                     // err only
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) sys_rdata_o <= rd_val;  // held until next read
  end

endmodule

/* dac_back.sv */
`timescale 1ns/1ps

module dac_back import analog_pkg::*; (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  sample_t          pid_a_i,
  input  sample_t          pid_b_i,
  input  sample_t          dc_a_i,       // dc level from ctrl regs
  input  sample_t          dc_b_i,
  output logic [ADC_W-1:0] dac_dat_a_o,  // neg-slope offset binary
  output logic [ADC_W-1:0] dac_dat_b_o,
  output sample_t          loop_a_o,     // same value, signed
  output sample_t          loop_b_o
);

  logic signed [SUM_W-1:0] sum_a;
  logic signed [SUM_W-1:0] sum_b;
  sample_t                 sat_a;
  sample_t                 sat_b;

  // one extra bit, cannot overflow
  assign sum_a = SUM_W'(dc_a_i) + SUM_W'(pid_a_i);
  assign sum_b = SUM_W'(dc_b_i) + SUM_W'(pid_b_i);

  assign sat_a = sat_to_sample(sum_a);
  assign sat_b = sat_to_sample(sum_b);

  // ------------------------------------------------------------------------
  // output registers, loop and pins from the same edge
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      loop_a_o    <= '0;
      loop_b_o    <= '0;
      dac_dat_a_o <= signed_to_nslope('0);  // signed zero on the pins
      dac_dat_b_o <= signed_to_nslope('0);
    end else begin
      loop_a_o    <= sat_a;
      loop_b_o    <= sat_b;
      dac_dat_a_o <= signed_to_nslope(sat_a);
      dac_dat_b_o <= signed_to_nslope(sat_b);
    end
  end

endmodule

/* hk_regs.sv */
`timescale 1ns/1ps

module hk_regs import analog_pkg::*; #(
  parameter int LED_W = 8
) (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  logic [BUS_W-1:0] sys_addr_i,
  input  logic [BUS_W-1:0] sys_wdata_i,
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  output logic [BUS_W-1:0] sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o,
  output logic             digital_loop_o,  // adc input from dac side
  output logic [LED_W-1:0] led_o
);

  sys_addr_u        addr_u;
  logic             rd_ok;
  logic             wr_ok;
  logic [BUS_W-1:0] rd_val;

  assign addr_u.raw = sys_addr_i;

  // ------------------------------------------------------------------------
  // offset decode
  always_comb begin
    rd_ok  = 1'b1;
    wr_ok  = 1'b1;
    rd_val = '0;
    case (addr_u.f.offset)
      HK_OFS_ID: begin
        rd_val = HK_ID;
        wr_ok  = 1'b0;  // id is read only
      end
      HK_OFS_LOOP: rd_val = BUS_W'(digital_loop_o);
      HK_OFS_LED:  rd_val = BUS_W'(led_o);
      default: begin
        rd_ok = 1'b0;
        wr_ok = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------------------
  // control regs and handshake
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      sys_ack_o      <= 1'b0;
      sys_err_o      <= 1'b0;
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;                              // one cycle answer
      sys_err_o <= (sys_wen_i & ~wr_ok) | (sys_ren_i & ~rd_ok);
      if (sys_wen_i && addr_u.f.offset == HK_OFS_LOOP) digital_loop_o <= sys_wdata_i[0];
      if (sys_wen_i && addr_u.f.offset == HK_OFS_LED)  led_o <= sys_wdata_i[LED_W-1:0];
    end
  end

  // read data, valid with ack
  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) sys_rdata_o <= rd_val;
  end

  // enable is a single pulse per access, so ack lasts one cycle
  a_ack_single: assert property (@(posedge adc_clk) disable iff (reset_i)
    sys_ack_o |=> !sys_ack_o);

endmodule

/* prop_ctrl.sv */
`timescale 1ns/1ps

module prop_ctrl import analog_pkg::*; #(
  parameter int KP_SHIFT = 8  // gain of 1 << KP_SHIFT is unity
) (
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  sample_t                adc_a_i,
  input  sample_t                adc_b_i,
  input  logic signed [KP_W-1:0] kp_a_i,
  input  logic signed [KP_W-1:0] kp_b_i,
  output sample_t                pid_a_o,
  output sample_t                pid_b_o
);

  localparam int PROD_W = ADC_W + KP_W;  // full product

  logic signed [PROD_W-1:0] prod_a_q;
  logic signed [PROD_W-1:0] prod_b_q;
  logic signed [PROD_W-1:0] shf_a;
  logic signed [PROD_W-1:0] shf_b;

  // ------------------------------------------------------------------------
  // stage 1, product
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      prod_a_q <= '0;
      prod_b_q <= '0;
    end else begin
      prod_a_q <= adc_a_i * kp_a_i;
      prod_b_q <= adc_b_i * kp_b_i;
    end
  end

  // arithmetic shift, floors toward minus infinity
  assign shf_a = prod_a_q >>> KP_SHIFT;
  assign shf_b = prod_b_q >>> KP_SHIFT;

  // ------------------------------------------------------------------------
  // stage 2, clamp to sample range
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      pid_a_o <= '0;
      pid_b_o <= '0;
    end else begin
      pid_a_o <= sat_to_sample(shf_a);
      pid_b_o <= sat_to_sample(shf_b);
    end
  end

  // outputs stay known once out of reset
  a_pid_known: assert property (@(posedge adc_clk) disable iff (reset_i)
    !$isunknown({pid_a_o, pid_b_o}));

endmodule

/* sys_bus_decoder.sv */
`timescale 1ns/1ps

module sys_bus_decoder import analog_pkg::*; (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  logic [BUS_W-1:0] sys_addr_i,    // held until ack
  input  logic             sys_wen_i,
  input  logic             sys_ren_i,
  input  logic [BUS_W-1:0] hk_rdata_i,
  input  logic             hk_ack_i,
  input  logic             hk_err_i,
  input  logic [BUS_W-1:0] ctrl_rdata_i,
  input  logic             ctrl_ack_i,
  input  logic             ctrl_err_i,
  output logic             hk_wen_o,
  output logic             hk_ren_o,
  output logic             ctrl_wen_o,
  output logic             ctrl_ren_o,
  output logic [BUS_W-1:0] sys_rdata_o,
  output logic             sys_ack_o,
  output logic             sys_err_o
);

  sys_addr_u         addr_u;
  logic [N_REGION-1:0] sel;     // one-hot region select
  logic              nul_sel;   // any of the six empty regions
  logic              nul_ack_q;

  assign addr_u.raw = sys_addr_i;
  assign sel        = N_REGION'(1) << addr_u.f.region;
  assign nul_sel    = ~(sel[REGION_HK] | sel[REGION_CTRL]);

  // enables gated by region
  assign hk_wen_o   = sel[REGION_HK]   & sys_wen_i;
  assign hk_ren_o   = sel[REGION_HK]   & sys_ren_i;
  assign ctrl_wen_o = sel[REGION_CTRL] & sys_wen_i;
  assign ctrl_ren_o = sel[REGION_CTRL] & sys_ren_i;

  // empty regions answer one cycle later, zero data, no error
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      nul_ack_q <= 1'b0;
    end else begin
      nul_ack_q <= nul_sel & (sys_wen_i | sys_ren_i);
    end
  end

  // answer mux, by region of the held address
  always_comb begin
    sys_rdata_o = '0;
    sys_ack_o   = nul_ack_q;
    sys_err_o   = 1'b0;
    if (sel[REGION_HK]) begin
      sys_rdata_o = hk_rdata_i;
      sys_ack_o   = hk_ack_i;
      sys_err_o   = hk_err_i;
    end else if (sel[REGION_CTRL]) begin
      sys_rdata_o = ctrl_rdata_i;
      sys_ack_o   = ctrl_ack_i;
      sys_err_o   = ctrl_err_i;
    end
  end

  // master never reads and writes in the same cycle
  a_no_rw_clash: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(sys_wen_i && sys_ren_i));

endmodule

/* tb.f */
analog_pkg.sv
sys_bus_decoder.sv
hk_regs.sv
ctrl_regs.sv
adc_front.sv
prop_ctrl.sv
dac_back.sv
analog_core.sv
tb_analog_core.sv

/* tb_analog_core.sv */
`timescale 1ns/1ps

module tb_analog_core import analog_pkg::*; ();

  localparam int KP_SHIFT   = 8;
  localparam int LED_W      = 8;
  localparam int S_MAX      = 2**(ADC_W-1) - 1;
  localparam int S_MIN      = -(2**(ADC_W-1));
  localparam int UNITY      = 1 << KP_SHIFT;
  localparam int MAX_CYCLES = 3000;  // tests take ~1300 cycles
  localparam logic [ADC_W-1:0] LOW_BITS = {1'b0, {(ADC_W-1){1'b1}}};

  logic               adc_clk, reset_i;
  logic [ADC_W-1:0]   adc_dat_a_i, adc_dat_b_i, dac_dat_a_o, dac_dat_b_o;
  logic [LED_W-1:0]   led_o;
  logic [BUS_W-1:0]   sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic               sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  logic [31:0]        lfsr = 32'hba7ee414;
  logic [31:0]        rnd_a, rnd_b;
  logic [2*ADC_W-1:0] exp_q[$];   // expected {a, b}, four deep
  logic [2*ADC_W-1:0] exp_pair;
  logic               chk_en = 1'b0;
  int                 dc_a_m, dc_b_m, kp_a_m, kp_b_m;  // model copy of ctrl regs
  int                 data_errs = 0;
  int                 bus_errs = 0;
  int                 sat_hi = 0;
  int                 sat_lo = 0;
  int                 cycles = 0;

  analog_core #(.KP_SHIFT(KP_SHIFT), .LED_W(LED_W)) i_dut (
    .adc_clk     (adc_clk),      .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),  .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),  .dac_dat_b_o (dac_dat_b_o),  .led_o (led_o),
    .sys_addr_i  (sys_addr_i),   .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),  .sys_ack_o   (sys_ack_o),    .sys_err_o (sys_err_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;
  end

  // ------------------------------------------------------------------------
  // reference model
  function automatic int code_to_int(input logic [ADC_W-1:0] code);
    logic [ADC_W-1:0] flip;
    flip = code ^ LOW_BITS;  // msb kept, rest inverted
    return flip[ADC_W-1] ? int'(flip) - 2**ADC_W : int'(flip);
  endfunction

  function automatic logic [ADC_W-1:0] int_to_code(input int s);
    logic [ADC_W-1:0] raw;
    raw = s[ADC_W-1:0];
    return raw ^ LOW_BITS;
  endfunction

  function automatic int clamp(input longint v);
    if (v > S_MAX) return S_MAX;
    if (v < S_MIN) return S_MIN;
    return int'(v);
  endfunction

  // product, floor shift, clamp, then dc added and clamped again
  function automatic int model_sample(input int s, input int dc, input int kp);
    longint prod;
    prod = longint'(s) * longint'(kp);
    return clamp(longint'(dc) + longint'(clamp(prod >>> KP_SHIFT)));
  endfunction

  function automatic logic [ADC_W-1:0] expected_dac(input logic [ADC_W-1:0] code,
                                                    input int dc, input int kp);
    return int_to_code(model_sample(code_to_int(code), dc, kp));
  endfunction

  // loopback: output fed back until it stops moving
  function automatic int settle_value(input int dc, input int kp);
    int x;
    int n;
    x = 0;
    n = 0;
    while (model_sample(x, dc, kp) != x && n < 100000) begin
      x = model_sample(x, dc, kp);
      n++;
    end
    return x;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;  // galois, right shifting
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [BUS_W-1:0] reg_addr(input logic [2:0] region, input logic [19:0] ofs);
    return {9'b0, region, ofs};
  endfunction

  // ------------------------------------------------------------------------
  // bus access, enable for one cycle, answer due the cycle after
  task automatic bus_check(input logic [BUS_W-1:0] addr, input logic [BUS_W-1:0] wdata,
                           input logic write, input logic [BUS_W-1:0] exp_data,
                           input logic exp_err);
    @(posedge adc_clk);
    sys_addr_i  <= addr;   // held until the next access
    sys_wdata_i <= wdata;
    sys_wen_i   <= write;
    sys_ren_i   <= ~write;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    @(negedge adc_clk);
    if (sys_ack_o !== 1'b1) begin
      bus_errs++;
      $display("no ack one cycle after the access to address %h", addr);
    end
    if (sys_err_o !== exp_err) begin
      bus_errs++;
      $display("[FAIL] sys_err_o addr %h got %h exp %h", addr, sys_err_o, exp_err);
    end
    if (!write && !exp_err && sys_rdata_o !== exp_data) begin
      bus_errs++;
      $display("[FAIL] sys_rdata_o addr %h got %h exp %h", addr, sys_rdata_o, exp_data);
    end
  endtask

  task automatic write_readback(input logic [19:0] ofs, input logic [BUS_W-1:0] wdata,
                                input int w);
    logic [BUS_W-1:0] keep;
    keep = (BUS_W'(1) << w) - 1;
    bus_check(reg_addr(REGION_CTRL, ofs), wdata, 1'b1, '0, 1'b0);
    bus_check(reg_addr(REGION_CTRL, ofs), '0, 1'b0,
              wdata[w-1] ? wdata | ~keep : wdata & keep, 1'b0);  // sign extended
  endtask

  task automatic set_path(input int dc_a, input int dc_b, input int kp_a, input int kp_b);
    dc_a_m = dc_a;
    dc_b_m = dc_b;
    kp_a_m = kp_a;
    kp_b_m = kp_b;
    bus_check(reg_addr(REGION_CTRL, CTRL_OFS_DC_A), 32'(dc_a), 1'b1, '0, 1'b0);
    bus_check(reg_addr(REGION_CTRL, CTRL_OFS_DC_B), 32'(dc_b), 1'b1, '0, 1'b0);
    bus_check(reg_addr(REGION_CTRL, CTRL_OFS_KP_A), 32'(kp_a), 1'b1, '0, 1'b0);
    bus_check(reg_addr(REGION_CTRL, CTRL_OFS_KP_B), 32'(kp_b), 1'b1, '0, 1'b0);
  endtask

  task automatic run_check(input int n);
    @(posedge adc_clk);
    chk_en = 1'b1;
    repeat (n) @(posedge adc_clk);
    chk_en = 1'b0;
  endtask

  // dac outputs unchanged for 8 cycles, two loop round trips
  task automatic wait_settle(input int limit);
    logic [2*ADC_W-1:0] last;
    int stable;
    int n;
    stable = 0;
    n      = 0;
    last   = {dac_dat_a_o, dac_dat_b_o};
    while (stable < 8 && n < limit) begin
      @(negedge adc_clk);
      n++;
      stable = ({dac_dat_a_o, dac_dat_b_o} == last) ? stable + 1 : 0;
      last   = {dac_dat_a_o, dac_dat_b_o};
    end
    if (stable < 8) begin
      data_errs++;
      $display("DAC outputs did not settle in loopback within %0d cycles", limit);
    end
  endtask

  // ------------------------------------------------------------------------
  // stimulus, checker, timeout
  always @(posedge adc_clk) begin
    draw_bits(ADC_W, rnd_a);
    draw_bits(ADC_W, rnd_b);
    adc_dat_a_i <= rnd_a[ADC_W-1:0];
    adc_dat_b_i <= rnd_b[ADC_W-1:0];
  end

  always @(negedge adc_clk) begin
    if (!chk_en) begin
      exp_q.delete();
    end else begin
      exp_q.push_back({expected_dac(adc_dat_a_i, dc_a_m, kp_a_m),
                       expected_dac(adc_dat_b_i, dc_b_m, kp_b_m)});
      if (exp_q.size() > 4) begin  // pin to pin latency
        exp_pair = exp_q.pop_front();
        if (dac_dat_a_o !== exp_pair[2*ADC_W-1:ADC_W]) begin
          data_errs++;
          $display("[FAIL] dac_dat_a_o got %h exp %h", dac_dat_a_o, exp_pair[2*ADC_W-1:ADC_W]);
        end
        if (dac_dat_b_o !== exp_pair[ADC_W-1:0]) begin
          data_errs++;
          $display("[FAIL] dac_dat_b_o got %h exp %h", dac_dat_b_o, exp_pair[ADC_W-1:0]);
        end
        if (exp_pair[2*ADC_W-1:ADC_W] == int_to_code(S_MAX)) sat_hi++;
        if (exp_pair[ADC_W-1:0] == int_to_code(S_MAX)) sat_hi++;
        if (exp_pair[2*ADC_W-1:ADC_W] == int_to_code(S_MIN)) sat_lo++;
        if (exp_pair[ADC_W-1:0] == int_to_code(S_MIN)) sat_lo++;
      end
    end
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, tests did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: data %0d, bus %0d", data_errs, bus_errs);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    reset_i     <= 1'b1;
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    sys_addr_i  <= '0;
    sys_wdata_i <= '0;
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    repeat (8) @(posedge adc_clk);
    reset_i <= 1'b0;
    repeat (6) @(negedge adc_clk);

    // reset state
    if (dac_dat_a_o !== int_to_code(0) || dac_dat_b_o !== int_to_code(0)) begin
      data_errs++;
      $display("[FAIL] dac_dat_a_o/dac_dat_b_o got %h/%h exp %h",
               dac_dat_a_o, dac_dat_b_o, int_to_code(0));
    end
    if (led_o !== '0) begin
      data_errs++;
      $display("[FAIL] led_o got %h exp %h", led_o, {LED_W{1'b0}});
    end
    bus_check(reg_addr(REGION_HK, HK_OFS_ID), '0, 1'b0, HK_ID, 1'b0);

    // register access and bus errors
    bus_check(reg_addr(REGION_HK, HK_OFS_LED), 32'hffff_ffa5, 1'b1, '0, 1'b0);
    bus_check(reg_addr(REGION_HK, HK_OFS_LED), '0, 1'b0,
              32'hffff_ffa5 & ((32'd1 << LED_W) - 1), 1'b0);
    if (led_o !== 8'ha5) begin
      data_errs++;
      $display("[FAIL] led_o got %h exp %h", led_o, 8'ha5);
    end
    write_readback(CTRL_OFS_DC_A, 32'h0000_3abc, ADC_W);
    write_readback(CTRL_OFS_DC_B, 32'h1234_0123, ADC_W);
    write_readback(CTRL_OFS_KP_A, 32'h0000_07ff, KP_W);
    write_readback(CTRL_OFS_KP_B, 32'h0000_0f12, KP_W);
    bus_check(reg_addr(REGION_HK, HK_OFS_ID), 32'h1234_5678, 1'b1, '0, 1'b1);
    bus_check(reg_addr(REGION_HK, HK_OFS_ID), '0, 1'b0, HK_ID, 1'b0);  // id untouched
    bus_check(reg_addr(REGION_HK, 20'h10), '0, 1'b0, '0, 1'b1);
    bus_check(reg_addr(REGION_CTRL, 20'h20), 32'h1, 1'b1, '0, 1'b1);
    bus_check(reg_addr(3'd5, 20'h40), '0, 1'b0, '0, 1'b0);  // empty region

    // dc only, then random codes through several gains
    set_path(1234, -4321, 0, 0);
    run_check(60);
    set_path(0, 0, 300, -77);
    run_check(300);
    set_path(2000, -3000, 2047, -2048);  // drives both limits
    run_check(300);
    set_path(-500, 700, UNITY, -UNITY);
    run_check(300);
    if (sat_hi == 0 || sat_lo == 0) begin
      data_errs++;
      $display("random test never drove the DAC into both saturation limits");
    end

    // loopback, pin data ignored
    set_path(1000, -1500, UNITY, UNITY);
    bus_check(reg_addr(REGION_HK, HK_OFS_LOOP), 32'h1, 1'b1, '0, 1'b0);
    bus_check(reg_addr(REGION_HK, HK_OFS_LOOP), '0, 1'b0, 32'h1, 1'b0);
    wait_settle(200);
    if (dac_dat_a_o !== int_to_code(settle_value(1000, UNITY))) begin
      data_errs++;
      $display("[FAIL] dac_dat_a_o got %h exp %h", dac_dat_a_o,
               int_to_code(settle_value(1000, UNITY)));
    end
    if (dac_dat_b_o !== int_to_code(settle_value(-1500, UNITY))) begin
      data_errs++;
      $display("[FAIL] dac_dat_b_o got %h exp %h", dac_dat_b_o,
               int_to_code(settle_value(-1500, UNITY)));
    end

    $display("errors: data %0d, bus %0d", data_errs, bus_errs);
    if (data_errs == 0 && bus_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
